//--- gpio_soc.f
common/gpio_soc_cmd_pkg.sv
common/gpio_soc_pad_pkg.sv
common/gpio_soc_op_if.sv
common/gpio_soc_res_if.sv
verilog/gpio_soc_decode.sv
gpio_ctrl/gpio_soc_execute.sv
verilog/gpio_soc_result.sv
verilog/gpio_soc_top.sv
verif/vip_gpio_soc.sv
verif/fixture_gpio_soc.sv

//--- run.sh
#!/bin/sh
# Compile and run the GPIO SoC testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module fixture_gpio_soc -Mdir obj_dir -f gpio_soc.f

out=$(./obj_dir/Vfixture_gpio_soc)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "all tests passed"; then
  exit 0
fi
exit 1

//--- verif/fixture_gpio_soc.sv
/*
 * GPIO SoC fixture
 * Clock, reset, the DUT and the pad resolution between the DUT
 * and the pin model
 */

`default_nettype none

module fixture_gpio_soc
  import gpio_soc_cmd_pkg::*;
  import gpio_soc_pad_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned NumGpio     = 8;
  localparam int unsigned ResultDepth = 2;
  localparam int unsigned RunCycles   = 20000;

  logic               clk;
  logic               arst_n;
  logic               cmd_valid;
  logic               cmd_ready;
  gpio_op_e           cmd_op;
  pad_word_t          cmd_data;
  logic               rsp_valid;
  logic               rsp_ready;
  rsp_status_e        rsp_status;
  pad_word_t          rsp_data;
  logic [NumGpio-1:0] gpio_out;
  logic [NumGpio-1:0] gpio_en;
  logic [NumGpio-1:0] pin_drive;
  wire  [NumGpio-1:0] pads;
  logic               done;
  logic               timed_out;
  int                 value_errors;
  int                 other_errors;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    arst_n = 1'b0;
    repeat (10) @(posedge clk);
    #1 arst_n = 1'b1;
  end

  // Pin follows the DUT where enabled, the pin model elsewhere
  assign pads = (gpio_en & gpio_out) | (~gpio_en & pin_drive);

  gpio_soc_top #(
    .NumGpio      ( NumGpio     ),
    .ResultDepth  ( ResultDepth )
  ) dut0 (
    .clk_i        ( clk        ),
    .arst_n_i     ( arst_n     ),
    .cmd_valid_i  ( cmd_valid  ),
    .cmd_ready_o  ( cmd_ready  ),
    .cmd_op_i     ( cmd_op     ),
    .cmd_data_i   ( cmd_data   ),
    .rsp_valid_o  ( rsp_valid  ),
    .rsp_ready_i  ( rsp_ready  ),
    .rsp_status_o ( rsp_status ),
    .rsp_data_o   ( rsp_data   ),
    .gpio_i       ( pads       ),
    .gpio_o       ( gpio_out   ),
    .gpio_en_o    ( gpio_en    )
  );

  vip_gpio_soc #(
    .NumGpio        ( NumGpio )
  ) vip (
    .clk_i          ( clk          ),
    .arst_n_i       ( arst_n       ),
    .cmd_valid_o    ( cmd_valid    ),
    .cmd_ready_i    ( cmd_ready    ),
    .cmd_op_o       ( cmd_op       ),
    .cmd_data_o     ( cmd_data     ),
    .rsp_valid_i    ( rsp_valid    ),
    .rsp_ready_o    ( rsp_ready    ),
    .rsp_status_i   ( rsp_status   ),
    .rsp_data_i     ( rsp_data     ),
    .dut_gpio_i     ( gpio_out     ),
    .dut_gpio_en_i  ( gpio_en      ),
    .pin_drive_o    ( pin_drive    ),
    .done_o         ( done         ),
    .timed_out_o    ( timed_out    ),
    .value_errors_o ( value_errors ),
    .other_errors_o ( other_errors )
  );

  //////////////////////////////
  // End of run
  //////////////////////////////

  initial begin : end_of_run
    int cycles;
    int other_total;
    cycles = 0;
    while (!done && cycles < RunCycles) begin
      @(posedge clk);
      cycles++;
    end
    other_total = other_errors;
    if (!done) begin
      other_total++;
      $display("Run did not finish within %0d cycles", RunCycles);
    end
    $display("Errors: value %0d, other %0d", value_errors, other_total);
    if (done && !timed_out && value_errors == 0 && other_total == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/vip_gpio_soc.sv
/*
 * GPIO SoC verification model
 * Random command driver, pin driver, reference model and checks
 */

`default_nettype none

module vip_gpio_soc
  import gpio_soc_cmd_pkg::*;
  import gpio_soc_pad_pkg::*;
#(
  parameter int unsigned NumGpio   = 8,
  parameter int unsigned NumCmds   = 400,
  parameter int unsigned WaitLimit = 200
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  output logic               cmd_valid_o,
  input  logic               cmd_ready_i,
  output gpio_op_e           cmd_op_o,
  output pad_word_t          cmd_data_o,
  input  logic               rsp_valid_i,
  output logic               rsp_ready_o,
  input  rsp_status_e        rsp_status_i,
  input  pad_word_t          rsp_data_i,
  input  logic [NumGpio-1:0] dut_gpio_i,
  input  logic [NumGpio-1:0] dut_gpio_en_i,
  output logic [NumGpio-1:0] pin_drive_o,
  output logic               done_o,
  output logic               timed_out_o,
  output int                 value_errors_o,
  output int                 other_errors_o
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam pad_word_t Mask = pad_word_t'((64'd1 << NumGpio) - 64'd1);

  pad_word_t   model_out;
  pad_word_t   model_en;
  pad_word_t   model_scratch;
  rsp_status_e exp_status_q [$];
  pad_word_t   exp_data_q   [$];
  int          seed;
  bit          pins_dirty;

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  task automatic check_word(input string name, input pad_word_t got, input pad_word_t exp);
    assert (got == exp) else begin
      value_errors_o++;
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_registers();
    check_word("gpio_o", pad_word_t'(dut_gpio_i), model_out);
    check_word("gpio_en_o", pad_word_t'(dut_gpio_en_i), model_en);
  endtask

  task automatic expect_rsp(input rsp_status_e status, input pad_word_t data);
    exp_status_q.push_back(status);
    exp_data_q.push_back(data);
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  task automatic model_command(input logic [2:0] code, input pad_word_t data);
    pad_word_t wr;
    pad_word_t pads;
    wr   = data & Mask;
    pads = ((model_out & model_en) | (pad_word_t'(pin_drive_o) & ~model_en)) & Mask;
    case (code)
      OP_WR_OUT: begin
        model_out = wr;
        expect_rsp(RSP_OK, wr);
      end
      OP_WR_EN: begin
        model_en = wr;
        expect_rsp(RSP_OK, wr);
      end
      OP_WR_SCRATCH: begin
        model_scratch = wr;
        expect_rsp(RSP_OK, wr);
      end
      OP_RD_PADS:    expect_rsp(RSP_OK, pads);
      OP_RD_SCRATCH: expect_rsp(RSP_OK, model_scratch);
      default:       expect_rsp(RSP_ILLEGAL, '0);
    endcase
  endtask

  task automatic check_response();
    assert (exp_data_q.size() != 0) else begin
      other_errors_o++;
      $display("Response at %0t with no command outstanding", $time);
    end
    if (exp_data_q.size() != 0) begin
      check_word("rsp_status_o", pad_word_t'(rsp_status_i),
                 pad_word_t'(exp_status_q.pop_front()));
      check_word("rsp_data_o", rsp_data_i, exp_data_q.pop_front());
    end
  endtask

  // Samples handshakes mid-cycle and drives 1 ns after the edge
  task automatic step(output logic cmd_taken);
    logic [31:0] r;
    @(negedge clk_i);
    cmd_taken = cmd_valid_o && cmd_ready_i;
    if (rsp_valid_i && rsp_ready_o) begin
      check_response();
    end
    if (cmd_taken) begin
      model_command(cmd_op_o, cmd_data_o);
    end
    @(posedge clk_i);
    #1;
    r = rand_word();
    rsp_ready_o = r[0];
  endtask

  task automatic issue_command(input logic [2:0] code, input pad_word_t data);
    logic taken;
    int   waited;
    cmd_valid_o = 1'b1;
    cmd_op_o    = gpio_op_e'(code);
    cmd_data_o  = data;
    taken       = 1'b0;
    waited      = 0;
    while (!taken && waited < WaitLimit) begin
      step(taken);
      waited++;
    end
    assert (taken) else begin
      other_errors_o++;
      timed_out_o = 1'b1;
      $display("Command not accepted within %0d cycles at %0t", WaitLimit, $time);
    end
    cmd_valid_o = 1'b0;
  endtask

  task automatic drain();
    logic taken;
    int   waited;
    waited = 0;
    while (exp_data_q.size() != 0 && waited < WaitLimit) begin
      step(taken);
      waited++;
    end
    assert (exp_data_q.size() == 0) else begin
      other_errors_o++;
      timed_out_o = 1'b1;
      $display("%0d responses missing at %0t", exp_data_q.size(), $time);
    end
  endtask

  // Pads settle through the synchronizer before the next read
  task automatic settle_pins(input bit new_drive);
    logic        taken;
    logic [31:0] r;
    drain();
    check_registers();
    if (new_drive) begin
      r = rand_word();
      pin_drive_o = r[NumGpio-1:0];
    end
    repeat (4) step(taken);
    pins_dirty = 1'b0;
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin : stimulus
    logic [31:0] r;
    pad_word_t   data;
    int          n;
    int          waited;
    seed           = 94;
    cmd_valid_o    = 1'b0;
    cmd_op_o       = OP_WR_OUT;
    cmd_data_o     = '0;
    rsp_ready_o    = 1'b0;
    pin_drive_o    = '0;
    done_o         = 1'b0;
    timed_out_o    = 1'b0;
    value_errors_o = 0;
    other_errors_o = 0;
    model_out      = '0;
    model_en       = '0;
    model_scratch  = '0;
    pins_dirty     = 1'b0;
    waited         = 0;
    while (!arst_n_i && waited < WaitLimit) begin
      @(posedge clk_i);
      waited++;
    end
    assert (arst_n_i) else begin
      other_errors_o++;
      timed_out_o = 1'b1;
      $display("Reset never released");
    end
    @(posedge clk_i);
    #1;
    check_word("rsp_valid_o", pad_word_t'(rsp_valid_i), '0);
    check_word("cmd_ready_o", pad_word_t'(cmd_ready_i), pad_word_t'(1));
    check_registers();
    n = 0;
    while (n < NumCmds && !timed_out_o) begin
      r = rand_word();
      // Occasional new pin drive while idle
      if (r[7:4] == 4'd0) begin
        settle_pins(1'b1);
      end
      data = rand_word();
      if (r[2:0] == OP_RD_PADS && pins_dirty) begin
        settle_pins(1'b0);
      end
      if (r[2:0] == OP_WR_OUT || r[2:0] == OP_WR_EN) begin
        pins_dirty = 1'b1;
      end
      issue_command(r[2:0], data);
      n++;
    end
    drain();
    check_registers();
    done_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- verilog/gpio_soc_top.sv
/*
 * GPIO SoC pad controller
 * Decode, execute and result stages behind valid/ready command
 * and response ports
 */

`default_nettype none

module gpio_soc_top
  import gpio_soc_cmd_pkg::*;
  import gpio_soc_pad_pkg::*;
#(
  parameter int unsigned NumGpio     = 8,
  parameter int unsigned ResultDepth = 2
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  // Command port
  input  logic               cmd_valid_i,
  output logic               cmd_ready_o,
  input  gpio_op_e           cmd_op_i,
  input  pad_word_t          cmd_data_i,
  // Response port
  output logic               rsp_valid_o,
  input  logic               rsp_ready_i,
  output rsp_status_e        rsp_status_o,
  output pad_word_t          rsp_data_o,
  // Pads
  input  logic [NumGpio-1:0] gpio_i,
  output logic [NumGpio-1:0] gpio_o,
  output logic [NumGpio-1:0] gpio_en_o
);

  gpio_soc_op_if  op_if ();
  gpio_soc_res_if res_if ();

  gpio_soc_decode u_decode (
    .clk_i       ( clk_i       ),
    .arst_n_i    ( arst_n_i    ),
    .cmd_valid_i ( cmd_valid_i ),
    .cmd_ready_o ( cmd_ready_o ),
    .cmd_op_i    ( cmd_op_i    ),
    .cmd_data_i  ( cmd_data_i  ),
    .op          ( op_if       )
  );

  gpio_soc_execute #(
    .NumGpio   ( NumGpio )
  ) u_execute (
    .clk_i     ( clk_i     ),
    .arst_n_i  ( arst_n_i  ),
    .op        ( op_if     ),
    .res       ( res_if    ),
    .gpio_i    ( gpio_i    ),
    .gpio_o    ( gpio_o    ),
    .gpio_en_o ( gpio_en_o )
  );

  gpio_soc_result #(
    .ResultDepth  ( ResultDepth )
  ) u_result (
    .clk_i        ( clk_i        ),
    .arst_n_i     ( arst_n_i     ),
    .res          ( res_if       ),
    .rsp_valid_o  ( rsp_valid_o  ),
    .rsp_ready_i  ( rsp_ready_i  ),
    .rsp_status_o ( rsp_status_o ),
    .rsp_data_o   ( rsp_data_o   )
  );

endmodule

`default_nettype wire

//--- verilog/gpio_soc_result.sv
/*
 * GPIO SoC result stage
 * Circular response FIFO; its head drives the response port
 */

`default_nettype none

module gpio_soc_result
  import gpio_soc_cmd_pkg::*;
  import gpio_soc_pad_pkg::*;
#(
  parameter int unsigned ResultDepth = 2
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  gpio_soc_res_if.consumer  res,
  output logic              rsp_valid_o,
  input  logic              rsp_ready_i,
  output rsp_status_e       rsp_status_o,
  output pad_word_t         rsp_data_o
);

  localparam int unsigned PtrW = (ResultDepth > 1) ? $clog2(ResultDepth) : 1;
  localparam int unsigned CntW = $clog2(ResultDepth + 1);

  rsp_status_e     status_mem [ResultDepth];
  pad_word_t       data_mem   [ResultDepth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            push;
  logic            pop;

  assign res.ready = (count_q != CntW'(ResultDepth));
  assign push      = res.valid && res.ready;
  assign pop       = rsp_valid_o && rsp_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(ResultDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(ResultDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leave the count alone
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      status_mem[wr_ptr_q] <= res.status;
      data_mem[wr_ptr_q]   <= res.data;
    end
  end

  assign rsp_valid_o  = (count_q != '0);
  assign rsp_status_o = status_mem[rd_ptr_q];
  assign rsp_data_o   = data_mem[rd_ptr_q];

  a_count_bound : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    count_q <= CntW'(ResultDepth)
  );

endmodule

`default_nettype wire

//--- gpio_ctrl/gpio_soc_execute.sv
/*
 * GPIO SoC execute stage
 * Holds the output, enable and scratch registers, synchronizes
 * the pad inputs and turns each operation into one result
 */

`default_nettype none

module gpio_soc_execute
  import gpio_soc_cmd_pkg::*;
  import gpio_soc_pad_pkg::*;
#(
  parameter int unsigned NumGpio = 8
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  gpio_soc_op_if.consumer    op,
  gpio_soc_res_if.producer   res,
  input  logic [NumGpio-1:0] gpio_i,
  output logic [NumGpio-1:0] gpio_o,
  output logic [NumGpio-1:0] gpio_en_o
);

  logic [NumGpio-1:0] out_q;
  logic [NumGpio-1:0] en_q;
  logic [NumGpio-1:0] scratch_q;
  logic [NumGpio-1:0] sync_q1;
  logic [NumGpio-1:0] sync_q2;
  logic [NumGpio-1:0] wr_val;
  logic [NumGpio-1:0] pads_val;
  logic               op_fire;
  logic               res_valid_q;
  rsp_status_e        res_status_d;
  rsp_status_e        res_status_q;
  pad_word_t          res_data_d;
  pad_word_t          res_data_q;

  // Upper command bits are dropped
  assign wr_val   = op.data[NumGpio-1:0];
  // Driven pins read back their own output
  assign pads_val = (out_q & en_q) | (sync_q2 & ~en_q);

  assign op.ready = !res_valid_q || res.ready;
  assign op_fire  = op.valid && op.ready;

  //////////////////////////////
  // Result
  //////////////////////////////

  always_comb begin
    res_status_d = RSP_OK;
    res_data_d   = '0;
    if (op.illegal) begin
      res_status_d = RSP_ILLEGAL;
    end else begin
      case (op.op)
        OP_WR_OUT,
        OP_WR_EN,
        OP_WR_SCRATCH: res_data_d[NumGpio-1:0] = wr_val;
        OP_RD_PADS:    res_data_d[NumGpio-1:0] = pads_val;
        OP_RD_SCRATCH: res_data_d[NumGpio-1:0] = scratch_q;
        default:       res_status_d = RSP_ILLEGAL;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      res_valid_q <= 1'b0;
    end else if (op_fire) begin
      res_valid_q <= 1'b1;
    end else if (res.ready) begin
      res_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (op_fire) begin
      res_status_q <= res_status_d;
      res_data_q   <= res_data_d;
    end
  end

  assign res.valid  = res_valid_q;
  assign res.status = res_status_q;
  assign res.data   = res_data_q;

  //////////////////////////////
  // Pad registers
  //////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_q     <= '0;
      en_q      <= '0;
      scratch_q <= '0;
    end else if (op_fire && !op.illegal) begin
      case (op.op)
        OP_WR_OUT:     out_q     <= wr_val;
        OP_WR_EN:      en_q      <= wr_val;
        OP_WR_SCRATCH: scratch_q <= wr_val;
        default:       ;
      endcase
    end
  end

  // Two-flop input synchronizer
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= gpio_i;
      sync_q2 <= sync_q1;
    end
  end

  assign gpio_o    = out_q;
  assign gpio_en_o = en_q;

  // An offered operation stays put until this stage takes it
  a_op_hold : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    op.valid && !op.ready |=> op.valid && $stable(op.op) && $stable(op.data)
      && $stable(op.illegal)
  );

endmodule

`default_nettype wire

//--- verilog/gpio_soc_decode.sv
/*
 * GPIO SoC decode stage
 * Accepts commands, flags reserved opcodes and holds one
 * operation for the execute stage
 */

`default_nettype none

module gpio_soc_decode
  import gpio_soc_cmd_pkg::*;
  import gpio_soc_pad_pkg::*;
(
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              cmd_valid_i,
  output logic              cmd_ready_o,
  input  gpio_op_e          cmd_op_i,
  input  pad_word_t         cmd_data_i,
  gpio_soc_op_if.producer   op
);

  logic      valid_q;
  gpio_op_e  op_q;
  pad_word_t data_q;
  logic      illegal_q;
  logic      cmd_fire;

  // Stage can refill in the same cycle it is drained
  assign cmd_ready_o = !valid_q || op.ready;
  assign cmd_fire    = cmd_valid_i && cmd_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (cmd_fire) begin
      valid_q <= 1'b1;
    end else if (op.ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_fire) begin
      op_q      <= cmd_op_i;
      data_q    <= cmd_data_i;
      illegal_q <= !op_is_legal(cmd_op_i);
    end
  end

  assign op.valid   = valid_q;
  assign op.op      = op_q;
  assign op.data    = data_q;
  assign op.illegal = illegal_q;

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Driver holds the command until it is taken
  a_cmd_stable : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    cmd_valid_i && !cmd_ready_o |=> $stable(cmd_op_i) && $stable(cmd_data_i)
  );

endmodule

`default_nettype wire

//--- common/gpio_soc_res_if.sv
/*
 * Finished result channel
 * Carries one status and data pair from execute to the result FIFO
 */

`default_nettype none

interface gpio_soc_res_if
  import gpio_soc_cmd_pkg::*;
  import gpio_soc_pad_pkg::*;
();

  logic        valid;
  logic        ready;
  rsp_status_e status;
  pad_word_t   data;

  modport producer (output valid, status, data, input ready);
  modport consumer (input valid, status, data, output ready);

endinterface

`default_nettype wire

//--- common/gpio_soc_op_if.sv
/*
 * Decoded operation channel
 * Carries one operation from decode to execute with valid/ready
 */

`default_nettype none

interface gpio_soc_op_if
  import gpio_soc_cmd_pkg::*;
  import gpio_soc_pad_pkg::*;
();

  logic      valid;
  logic      ready;
  gpio_op_e  op;
  pad_word_t data;
  logic      illegal;

  modport producer (
    output valid, op, data, illegal,
    input  ready
  );

  modport consumer (
    input  valid, op, data, illegal,
    output ready
  );

endinterface

`default_nettype wire

//--- common/gpio_soc_pad_pkg.sv
/*
 * GPIO SoC pad definitions
 * Word type used by command data, response data and registers
 */

`default_nettype none

package gpio_soc_pad_pkg;

  // Upper limit on the number of pads
  localparam int unsigned MaxGpio = 32;

  // Bits above the configured pad count read back as zero
  typedef logic [MaxGpio-1:0] pad_word_t;

endpackage

`default_nettype wire

//--- common/gpio_soc_cmd_pkg.sv
/*
 * GPIO SoC command protocol
 * Opcodes accepted on the command port and the status returned
 * with every response
 */

`default_nettype none

package gpio_soc_cmd_pkg;

  //////////////////////////////
  // Opcodes
  //////////////////////////////

  // Codes 5 to 7 are reserved and answered as illegal
  typedef enum logic [2:0] {
    OP_WR_OUT     = 3'd0,
    OP_WR_EN      = 3'd1,
    OP_RD_PADS    = 3'd2,
    OP_WR_SCRATCH = 3'd3,
    OP_RD_SCRATCH = 3'd4
  } gpio_op_e;

  //////////////////////////////
  // Response status
  //////////////////////////////

  typedef enum logic {
    RSP_OK      = 1'b0,
    RSP_ILLEGAL = 1'b1
  } rsp_status_e;

  // True for the five defined opcodes only
  function automatic logic op_is_legal(input gpio_op_e op);
    logic legal;
    case (op)
      OP_WR_OUT,
      OP_WR_EN,
      OP_RD_PADS,
      OP_WR_SCRATCH,
      OP_RD_SCRATCH: legal = 1'b1;
      default:       legal = 1'b0;
    endcase
    return legal;
  endfunction

endpackage

`default_nettype wire
